/* Makefile */
# Verilator build and run of the encoder speed testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= enc_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TB PASSED

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/enc_tb_ref.svh */
// testbench LFSR step and reference models for position, edge kind and latched period
`ifndef enc_tb_ref_svh
`define enc_tb_ref_svh

// ----------------------------------------------------------------------------
// random source
// ----------------------------------------------------------------------------
// fibonacci form, taps 32 22 2 1, new bit enters at the lsb
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// ----------------------------------------------------------------------------
// reference models
// ----------------------------------------------------------------------------
// one count per legal step, signed
function automatic pos_t ref_position(input int fwd_steps, input int rev_steps);
    return pos_t'(fwd_steps - rev_steps);
endfunction

// edge kind of a single-line change, numbered like edge_src_e
function automatic logic [1:0] ref_edge_kind(input logic old_a, input logic new_a,
                                             input logic new_b);
    if (old_a != new_a) begin
        return new_a ? 2'd0 : 2'd1;   // a rise / a fall
    end
    return new_b ? 2'd2 : 2'd3;       // b rise / b fall
endfunction

// lower half of period once an edge of one kind arrives gap cycles after the last one
function automatic tick_count_t ref_latched(input int gap, input logic prev_dir,
                                            input logic cur_dir);
    int span;
    span = gap - 1;                   // clears on the pulse, then one count per cycle
    if (cur_dir != prev_dir) begin
        return period_sat;            // reversal inside the interval
    end
    if (span >= (1 << (tick_width - 1))) begin
        return period_sat;            // too slow, counter parked
    end
    return cur_dir ? tick_count_t'(span) : tick_count_t'(-span);
endfunction

`endif

/* dv/enc_tb.sv */
// testbench for the encoder speed core: clock, reset, quadrature stimulus, compare process, report
`timescale 1ns/100ps
`default_nettype none

module enc_tb
    import enc_pkg::*;
();

    typedef enum logic [1:0] {chk_step, chk_reset, chk_idle} chk_kind_e;

    logic    clk_fast = 1'b0;
    logic    reset;
    logic    a;
    logic    b;
    pos_t    position;
    logic    dir;
    logic    enc_error;
    period_t period;

    // request from stimulus to the compare process
    int          req_id  = 0;
    int          done_id = 0;
    chk_kind_e   req_kind;
    int          req_fwd;
    int          req_rev;
    logic        req_dir;
    logic        req_err;
    logic        req_lat_valid;   // own kind has a known reference
    int          req_gap;         // cycles since previous same-kind edge
    logic        req_prev_dir;
    logic        req_step_dir;
    logic        req_fwd_only;    // running half must be non-negative
    logic        stim_done = 1'b0;

    // stimulus-side model of the encoder
    logic [31:0] lfsr_state = 32'hc1e16707;
    logic [1:0]  gs;              // gray index with ab = 00 10 11 01
    int          stim_cyc;        // posedges since reset release
    int          fwd_cnt;
    int          rev_cnt;
    logic        last_dir;
    logic        err_model;
    logic        kind_seen [4];
    logic        kind_dir  [4];
    int          kind_cyc  [4];

    int n_checks      = 0;
    int value_errs    = 0;
    int cmp_timeouts  = 0;
    int wait_timeouts = 0;

    `include "enc_tb_ref.svh"

    always #20 clk_fast = ~clk_fast;   // 40 ns period

    enc_speed_top i_dut (
        .clk_fast  (clk_fast),
        .reset     (reset),
        .a         (a),
        .b         (b),
        .position  (position),
        .dir       (dir),
        .enc_error (enc_error),
        .period    (period)
    );

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_fast);
        stim_cyc += n;
    endtask

    task automatic next_gap(output int n);
        logic [5:0] bits;
        for (int i = 0; i < 6; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[4:0], lfsr_state[0]};   // one step per bit
        end
        n = 6 + int'(bits);   // 6 .. 69
    endtask

    task automatic post_check(input chk_kind_e kind);
        req_fwd  = fwd_cnt;
        req_rev  = rev_cnt;
        req_dir  = last_dir;
        req_err  = err_model;
        req_kind = kind;
        req_id++;
    endtask

    task automatic reset_dut();
        reset <= 1'b0;
        a     <= 1'b0;
        b     <= 1'b0;
        repeat (4) @(posedge clk_fast);
        reset <= 1'b1;
        gs        = 2'd0;   // model back to power-up
        stim_cyc  = 0;
        fwd_cnt   = 0;
        rev_cnt   = 0;
        last_dir  = 1'b1;
        err_model = 1'b0;
        for (int k = 0; k < 4; k++) begin
            kind_seen[k] = 1'b0;
            kind_dir[k]  = 1'b1;   // timers start forward
            kind_cyc[k]  = 0;
        end
        post_check(chk_reset);
    endtask

    task automatic do_step(input logic fwd, input int gap);
        logic [1:0] nxt;
        logic [1:0] k;
        wait_cycles(gap);
        nxt = fwd ? gs + 2'd1 : gs - 2'd1;
        k   = ref_edge_kind(gs[0] ^ gs[1], nxt[0] ^ nxt[1], nxt[1]);
        a <= nxt[0] ^ nxt[1];
        b <= nxt[1];
        req_lat_valid = kind_seen[k] || (kind_dir[k] != fwd);
        req_gap       = stim_cyc - kind_cyc[k];
        req_prev_dir  = kind_dir[k];
        req_step_dir  = fwd;
        req_fwd_only  = fwd;
        kind_seen[k]  = 1'b1;
        kind_dir[k]   = fwd;
        kind_cyc[k]   = stim_cyc;
        gs            = nxt;
        if (fwd) begin
            fwd_cnt++;
        end else begin
            rev_cnt++;
        end
        last_dir = fwd;
        post_check(chk_step);
    endtask

    // both lines flip in one cycle
    task automatic do_illegal(input int gap);
        wait_cycles(gap);
        gs = gs + 2'd2;
        a <= gs[0] ^ gs[1];
        b <= gs[1];
        err_model     = 1'b1;
        req_lat_valid = 1'b0;
        req_fwd_only  = 1'b0;
        post_check(chk_step);
    endtask

    task automatic wait_compare_idle();
        int waited;
        waited = 0;
        while (done_id != req_id && waited <= 20) begin
            @(negedge clk_fast);
            waited++;
        end
        if (done_id != req_id) begin
            $display("timeout: compare process never finished request %0d", req_id);
            wait_timeouts++;
        end
    endtask

    // ------------------------------------------------------------------------
    // compare side
    // ------------------------------------------------------------------------
    task automatic log_mismatch(input string what, input int got, input int exp);
        $display("ERROR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        value_errs++;
    endtask

    task automatic run_check();
        pos_t        exp_pos;
        tick_count_t exp_lat;
        int          spin;
        n_checks++;
        if (req_kind == chk_step) begin
            repeat (5) @(negedge clk_fast);   // period lands 4 cycles after the step
        end
        if (req_kind == chk_reset) begin
            spin = 0;
            while (reset !== 1'b1 && spin < 10) begin
                @(negedge clk_fast);
                spin++;
            end
            if (reset !== 1'b1) begin
                $display("timeout: reset was never released");
                cmp_timeouts++;
            end
            if (period !== '0) begin
                log_mismatch("period after reset", int'(period), 0);
            end
        end
        if (req_kind != chk_idle) begin
            exp_pos = ref_position(req_fwd, req_rev);
            if (position !== exp_pos) begin
                log_mismatch("position", int'(position), int'(exp_pos));
            end
            if (dir !== req_dir) begin
                log_mismatch("dir", int'(dir), int'(req_dir));
            end
            if (enc_error !== req_err) begin
                log_mismatch("enc_error", int'(enc_error), int'(req_err));
            end
        end
        if (req_kind == chk_step && req_lat_valid) begin
            exp_lat = ref_latched(req_gap, req_prev_dir, req_step_dir);
            if (tick_count_t'(period[15:0]) !== exp_lat) begin
                log_mismatch("latched period", int'(tick_count_t'(period[15:0])),
                             int'(exp_lat));
            end
        end
        if (req_kind == chk_step && req_fwd_only && period[31] !== 1'b0) begin
            log_mismatch("running period", int'(tick_count_t'(period[31:16])), 0);
        end
        if (req_kind == chk_idle && period !== {period_sat, period_sat}) begin
            log_mismatch("idle period word", int'(period), int'({period_sat, period_sat}));
        end
    endtask

    task automatic end_run();
        $display("checks %0d, value errors %0d, timeouts %0d", n_checks, value_errs,
                 cmp_timeouts + wait_timeouts);
        if (value_errs == 0 && cmp_timeouts == 0 && wait_timeouts == 0 && n_checks > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin : compare_proc
        int   waited;
        int   id;
        logic timed_out;
        timed_out = 1'b0;
        while (!stim_done && !timed_out) begin
            waited = 0;
            while (done_id == req_id && !stim_done && waited <= 40000) begin
                @(negedge clk_fast);
                waited++;
            end
            if (done_id != req_id) begin
                id = req_id;
                run_check();
                done_id = id;
            end else if (!stim_done) begin
                $display("timeout: no new step from the stimulus for %0d cycles", waited);
                cmp_timeouts++;
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            end_run();
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int n;
        reset_dut();
        for (int run = 0; run < 4; run++) begin   // forward at random constant gaps
            next_gap(n);
            for (int i = 0; i < 8; i++) begin
                do_step(1'b1, n);
            end
        end
        for (int run = 0; run < 3; run++) begin   // reversal
            next_gap(n);
            for (int i = 0; i < 8; i++) begin
                do_step(1'b0, n);
            end
        end
        for (int i = 0; i < 6; i++) begin         // slower than the counter range
            do_step(1'b1, 9000);
        end
        wait_cycles(33000);                        // running half parks at the sentinel
        post_check(chk_idle);
        wait_cycles(200);
        post_check(chk_idle);
        for (int i = 0; i < 4; i++) begin
            do_step(1'b1, 10);
        end
        do_illegal(10);
        for (int i = 0; i < 6; i++) begin         // error must stay set
            do_step(1'b1, 12);
        end
        wait_compare_idle();
        @(posedge clk_fast);
        reset_dut();                               // only a reset clears the error
        for (int i = 0; i < 4; i++) begin
            do_step(1'b1, 8);
        end
        wait_compare_idle();
        stim_done = 1'b1;
        end_run();
    end

endmodule

`default_nettype wire

/* src/enc_edge_timer.sv */
// period timer for one edge kind: signed saturating cycle counter, direction check and latch
`timescale 1ns/100ps
`default_nettype none

module enc_edge_timer
    import enc_pkg::*;
(
    input  logic        clk_fast,
    input  logic        reset,       // async, active low
    input  logic        edge_pulse,  // own edge kind, one cycle
    input  logic        step_dir,    // direction of this edge
    output tick_count_t running,     // cycles since last own edge
    output tick_count_t latched      // result of last full interval
);

    // ------------------------------------------------------------------------
    // stored direction
    // ------------------------------------------------------------------------
    logic dir_q;        // direction seen at previous own edge
    logic dir_flip;     // reversal inside this interval
    logic at_sat;       // counter parked at sentinel

    assign dir_flip = step_dir != dir_q;
    assign at_sat   = running == period_sat;

    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            dir_q <= 1'b1;   // forward
        end else if (edge_pulse) begin
            dir_q <= step_dir;
        end
    end

    // ------------------------------------------------------------------------
    // cycle counter
    // ------------------------------------------------------------------------
    // counts toward +/- full scale by stored dir; either way the next value
    // past the end is 16'h8000, where it stops until the next own edge
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            running <= '0;
        end else if (edge_pulse) begin
            running <= '0;                    // restart interval
        end else if (!at_sat) begin
            running <= dir_q ? running + tick_count_t'(1)
                             : running - tick_count_t'(1);
        end
    end

    // ------------------------------------------------------------------------
    // latch
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            latched <= '0;
        end else if (edge_pulse) begin
            if (dir_flip) begin
                latched <= period_sat;   // speed meaningless across a reversal
            end else begin
                latched <= running;      // already period_sat if too slow
            end
        end
    end

    // once parked, the counter only leaves through a restart
    a_no_step_past_sat: assert property (
        @(posedge clk_fast) disable iff (!reset)
        at_sat |=> (running == period_sat) || (running == '0)
    ) else $error("period counter stepped past saturation");

endmodule

`default_nettype wire

/* src/enc_pkg.sv */
// shared widths, typedefs, period sentinel and edge-source enum for the encoder speed core

package enc_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int pos_width    = 32;   // signed encoder position
    localparam int tick_width   = 16;   // signed cycle count per edge kind
    localparam int period_width = 2 * tick_width;  // {running, latched}

    // synchronizer depth on the raw encoder lines
    localparam int sync_stages = 2;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------
    typedef logic signed [pos_width-1:0]  pos_t;         // position in quadrature steps
    typedef logic signed [tick_width-1:0] tick_count_t;  // clk_fast cycles between edges
    typedef logic [period_width-1:0]      period_t;      // upper running, lower latched

    // overflow / direction-change marker, also where the counter parks
    localparam tick_count_t period_sat = 16'h8000;

    // which edge kind came last, order matches pulse priority
    typedef enum logic [1:0] {
        src_a_rise = 2'd0,
        src_a_fall = 2'd1,
        src_b_rise = 2'd2,
        src_b_fall = 2'd3
    } edge_src_e;

endpackage

/* src/enc_quad_decoder.sv */
// quadrature decoder with line synchronizer, edge pulses, step direction, position and error flag
`timescale 1ns/100ps
`default_nettype none

module enc_quad_decoder
    import enc_pkg::*;
(
    input  logic clk_fast,
    input  logic reset,       // async, active low
    input  logic a,           // raw encoder line a
    input  logic b,           // raw encoder line b
    output logic a_rise,      // one-cycle edge pulses
    output logic a_fall,
    output logic b_rise,
    output logic b_fall,
    output logic step_dir,    // 1 = forward, valid with a pulse
    output logic dir,         // direction of last legal step
    output pos_t position,
    output logic enc_error    // sticky until reset
);

    // ------------------------------------------------------------------------
    // synchronizer and previous-value register
    // ------------------------------------------------------------------------
    logic [sync_stages-1:0] a_sync;   // [sync_stages-1] is the usable level
    logic [sync_stages-1:0] b_sync;
    logic                   a_prev;
    logic                   b_prev;

    logic a_s;      // synchronized a
    logic b_s;      // synchronized b
    logic a_chg;
    logic b_chg;
    logic step;     // one legal edge this cycle
    logic illegal;  // both lines moved at once

    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            a_sync <= '0;
            b_sync <= '0;
            a_prev <= 1'b0;
            b_prev <= 1'b0;
        end else begin
            a_sync <= {a_sync[sync_stages-2:0], a};  // shift in raw line
            b_sync <= {b_sync[sync_stages-2:0], b};
            a_prev <= a_s;
            b_prev <= b_s;
        end
    end

    assign a_s = a_sync[sync_stages-1];
    assign b_s = b_sync[sync_stages-1];

    // ------------------------------------------------------------------------
    // edge and direction decode
    // ------------------------------------------------------------------------
    assign a_chg   = a_s ^ a_prev;
    assign b_chg   = b_s ^ b_prev;
    assign illegal = a_chg & b_chg;
    assign step    = a_chg ^ b_chg;    // exactly one line moved

    // double change gives no pulse at all
    assign a_rise = a_chg & ~b_chg &  a_s;
    assign a_fall = a_chg & ~b_chg & ~a_s;
    assign b_rise = b_chg & ~a_chg &  b_s;
    assign b_fall = b_chg & ~a_chg & ~b_s;

    // a leads b: a edge with lines now unequal, or b edge with lines now equal
    assign step_dir = a_chg ? (a_s ^ b_s) : ~(a_s ^ b_s);

    // ------------------------------------------------------------------------
    // position, direction, error
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            position  <= '0;
            dir       <= 1'b1;   // forward after reset
            enc_error <= 1'b0;
        end else begin
            if (step) begin
                position <= step_dir ? position + pos_t'(1) : position - pos_t'(1);
                dir      <= step_dir;
            end
            if (illegal) begin
                enc_error <= 1'b1;   // sticky
            end
        end
    end

    // error only clears through reset
    a_error_sticky: assert property (
        @(posedge clk_fast) disable iff (!reset)
        !$fell(enc_error)
    ) else $error("enc_error dropped without reset");

endmodule

`default_nettype wire

/* src/enc_quad_period.sv */
// four edge-kind period timers, last-edge source tracking and registered period word
`timescale 1ns/100ps
`default_nettype none

module enc_quad_period
    import enc_pkg::*;
(
    input  logic    clk_fast,
    input  logic    reset,      // async, active low
    input  logic    a_rise,
    input  logic    a_fall,
    input  logic    b_rise,
    input  logic    b_fall,
    input  logic    step_dir,   // forward when high
    output period_t period      // {running, latched} of latest edge kind
);

    // ------------------------------------------------------------------------
    // per-edge timers
    // ------------------------------------------------------------------------
    logic [3:0]  edge_pulses;   // bit order follows edge_src_e
    tick_count_t running [4];
    tick_count_t latched [4];

    assign edge_pulses = {b_fall, b_rise, a_fall, a_rise};

    for (genvar i = 0; i < 4; i++) begin : g_timer
        enc_edge_timer i_timer (
            .clk_fast   (clk_fast),
            .reset      (reset),
            .edge_pulse (edge_pulses[i]),
            .step_dir   (step_dir),
            .running    (running[i]),
            .latched    (latched[i])
        );
    end

    // ------------------------------------------------------------------------
    // latest edge source
    // ------------------------------------------------------------------------
    edge_src_e edge_src;

    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            edge_src <= src_a_rise;
        end else if (a_rise) begin   // a_rise wins if ever more than one
            edge_src <= src_a_rise;
        end else if (a_fall) begin
            edge_src <= src_a_fall;
        end else if (b_rise) begin
            edge_src <= src_b_rise;
        end else if (b_fall) begin
            edge_src <= src_b_fall;
        end
    end

    // ------------------------------------------------------------------------
    // period word
    // ------------------------------------------------------------------------
    // one cycle behind the timer latch, so the new edge's result is picked up
    always_ff @(posedge clk_fast or negedge reset) begin
        if (!reset) begin
            period <= '0;
        end else begin
            period <= {running[edge_src], latched[edge_src]};
        end
    end

    // decoder must never present two edges at once
    a_single_edge: assert property (
        @(posedge clk_fast) disable iff (!reset)
        $onehot0(edge_pulses)
    ) else $error("more than one edge pulse in a cycle");

endmodule

`default_nettype wire

/* src/enc_speed_top.sv */
// encoder speed top level: quadrature decoder feeding the period measurement block
`timescale 1ns/100ps
`default_nettype none

module enc_speed_top
    import enc_pkg::*;
(
    input  logic    clk_fast,
    input  logic    reset,       // async, active low
    input  logic    a,           // raw encoder lines
    input  logic    b,
    output pos_t    position,
    output logic    dir,         // 1 = forward
    output logic    enc_error,   // sticky
    output period_t period
);

    // decoder to period block
    logic a_rise;
    logic a_fall;
    logic b_rise;
    logic b_fall;
    logic step_dir;

    enc_quad_decoder i_decoder (
        .clk_fast  (clk_fast),
        .reset     (reset),
        .a         (a),
        .b         (b),
        .a_rise    (a_rise),
        .a_fall    (a_fall),
        .b_rise    (b_rise),
        .b_fall    (b_fall),
        .step_dir  (step_dir),
        .dir       (dir),
        .position  (position),
        .enc_error (enc_error)
    );

    enc_quad_period i_period (
        .clk_fast (clk_fast),
        .reset    (reset),
        .a_rise   (a_rise),
        .a_fall   (a_fall),
        .b_rise   (b_rise),
        .b_fall   (b_fall),
        .step_dir (step_dir),
        .period   (period)
    );

endmodule

`default_nettype wire

/* vlog.f */
+incdir+dv
src/enc_pkg.sv
src/enc_quad_decoder.sv
src/enc_edge_timer.sv
src/enc_quad_period.sv
src/enc_speed_top.sv
dv/enc_tb.sv
